//--- cnn_buf_params.svh
`ifndef CNN_BUF_PARAMS_SVH
`define CNN_BUF_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Payload widths
//////////////////////////////////////////////////////////////////////

// One bias word per FIFO entry
`define CNN_BIAS_W 16
`define CNN_WEIGHT_W 8
// Feature data word in the layer RAM
`define CNN_LAYER_W 16

//////////////////////////////////////////////////////////////////////
// Store depths
//////////////////////////////////////////////////////////////////////

`define CNN_FIFO_DEPTH 8
`define CNN_LAYER_DEPTH 16

`endif

//--- cnn_buf_pkg.sv
`include "cnn_buf_params.svh"

package cnn_buf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Payload words
    //////////////////////////////////////////////////////////////////////

    typedef logic [`CNN_BIAS_W-1:0]   bias_t;
    typedef logic [`CNN_WEIGHT_W-1:0] weight_t;
    typedef logic [`CNN_LAYER_W-1:0]  layer_t;

    // Layer RAM address
    typedef logic [$clog2(`CNN_LAYER_DEPTH)-1:0] layer_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Control and status
    //////////////////////////////////////////////////////////////////////

    // One bit per store, 1 means loading or reading it
    typedef struct packed {
        logic bias;
        logic weight;
        logic layer;
    } sel_t;

    // Data presented together with the load state
    typedef struct packed {
        bias_t   bias;
        weight_t weight;
        layer_t  layer;
    } load_word_t;

    // FIFO flag snapshot
    typedef struct packed {
        logic bias_full;
        logic bias_empty;
        logic weight_full;
        logic weight_empty;
    } mem_status_t;

    // Aligned operand word, valid bits first
    typedef struct packed {
        sel_t    valid;
        bias_t   bias;
        weight_t weight;
        layer_t  layer;
    } operand_t;

endpackage

//--- mem_ctrl.sv
`timescale 1ns/1ps
`include "cnn_buf_params.svh"

module mem_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ena,
    input  logic                     clear,
    input  cnn_buf_pkg::sel_t        load_state,
    input  cnn_buf_pkg::sel_t        read_state,
    input  logic                     bias_full,
    input  logic                     bias_empty,
    input  logic                     weight_full,
    input  logic                     weight_empty,
    output logic                     bias_wr,
    output logic                     bias_rd,
    output logic                     weight_wr,
    output logic                     weight_rd,
    output logic                     layer_we,
    output logic                     layer_re,
    output logic                     store_clr,
    output cnn_buf_pkg::layer_addr_t layer_wr_addr,
    output cnn_buf_pkg::layer_addr_t layer_rd_addr,
    output cnn_buf_pkg::sel_t        rd_issue,
    output logic                     load_done,
    output cnn_buf_pkg::mem_status_t mem_state
);

    // Last layer address before wrap
    localparam cnn_buf_pkg::layer_addr_t LAYER_LAST =
        cnn_buf_pkg::layer_addr_t'(`CNN_LAYER_DEPTH - 1);

    logic access_ok;

    //////////////////////////////////////////////////////////////////////
    // Enable decode
    //////////////////////////////////////////////////////////////////////

    // Clear takes the whole cycle, no access alongside it
    assign access_ok = ena & ~clear;
    assign store_clr = ena & clear;

    // Requests against a full or empty FIFO are dropped
    assign bias_wr   = access_ok & load_state.bias & ~bias_full;
    assign weight_wr = access_ok & load_state.weight & ~weight_full;
    assign bias_rd   = access_ok & read_state.bias & ~bias_empty;
    assign weight_rd = access_ok & read_state.weight & ~weight_empty;

    // Layer RAM has no flags
    assign layer_we = access_ok & load_state.layer;
    assign layer_re = access_ok & read_state.layer;

    // Reads actually issued this cycle
    assign rd_issue.bias   = bias_rd;
    assign rd_issue.weight = weight_rd;
    assign rd_issue.layer  = layer_re;

    //////////////////////////////////////////////////////////////////////
    // Layer pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            layer_wr_addr <= '0;
            layer_rd_addr <= '0;
        end
        else if (store_clr)
        begin
            layer_wr_addr <= '0;
            layer_rd_addr <= '0;
        end
        else
        begin
            if (layer_we)
            begin
                layer_wr_addr <= (layer_wr_addr == LAYER_LAST) ? '0 : layer_wr_addr + 1'b1;
            end
            if (layer_re)
            begin
                layer_rd_addr <= (layer_rd_addr == LAYER_LAST) ? '0 : layer_rd_addr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load-done flag and status snapshot
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_done              <= 1'b0;
            mem_state.bias_full    <= 1'b0;
            mem_state.bias_empty   <= 1'b1;
            mem_state.weight_full  <= 1'b0;
            mem_state.weight_empty <= 1'b1;
        end
        else if (ena)
        begin
            // Done once the loader drops every bit
            load_done              <= (load_state == '0);
            mem_state.bias_full    <= bias_full;
            mem_state.bias_empty   <= bias_empty;
            mem_state.weight_full  <= weight_full;
            mem_state.weight_empty <= weight_empty;
        end
    end

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps
`include "cnn_buf_params.svh"

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `CNN_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic clr,
    input  logic wr,
    input  logic rd,
    input  T     din,
    output T     dout,
    output logic full,
    output logic empty
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
    localparam logic [AW:0] COUNT_FULL = (AW + 1)'(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == COUNT_FULL);
    assign empty = (count == '0);

    // Guard against overrun and underrun locally as well
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (clr)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Read plus write leaves the count alone
            if (do_wr && !do_rd)
            begin
                count <= count + 1'b1;
            end
            else if (do_rd && !do_wr)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and registered read port
    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= din;
        end
        if (do_rd)
        begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

//--- layer_ram.sv
`timescale 1ns/1ps
`include "cnn_buf_params.svh"

module layer_ram (
    input  logic                     clk,
    input  logic                     we,
    input  cnn_buf_pkg::layer_addr_t wr_addr,
    input  cnn_buf_pkg::layer_addr_t rd_addr,
    input  cnn_buf_pkg::layer_t      wr_data,
    input  logic                     re,
    output cnn_buf_pkg::layer_t      rd_data
);

    //////////////////////////////////////////////////////////////////////
    // Feature data array
    //////////////////////////////////////////////////////////////////////

    cnn_buf_pkg::layer_t mem [`CNN_LAYER_DEPTH];

    // Write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, registered
    // Same-address collision returns the word before the write
    always_ff @(posedge clk)
    begin
        if (re)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- operand_gather.sv
`timescale 1ns/1ps

module operand_gather (
    input  logic                  clk,
    input  logic                  rst,
    input  cnn_buf_pkg::sel_t     rd_issue,
    input  cnn_buf_pkg::bias_t    bias_data,
    input  cnn_buf_pkg::weight_t  weight_data,
    input  cnn_buf_pkg::layer_t   layer_data,
    output cnn_buf_pkg::operand_t operand
);

    // Issue bits delayed to match the store output registers
    cnn_buf_pkg::sel_t issue_d;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            issue_d <= '0;
        end
        else
        begin
            issue_d <= rd_issue;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            operand <= '0;
        end
        else
        begin
            // One valid pulse per issued read
            operand.valid <= issue_d;
            // Fields not read keep their old data
            if (issue_d.bias)
            begin
                operand.bias <= bias_data;
            end
            if (issue_d.weight)
            begin
                operand.weight <= weight_data;
            end
            if (issue_d.layer)
            begin
                operand.layer <= layer_data;
            end
        end
    end

endmodule

//--- cnn_buf_top.sv
`timescale 1ns/1ps
`include "cnn_buf_params.svh"

module cnn_buf_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ena,
    input  logic                     clear,
    input  cnn_buf_pkg::sel_t        load_state,
    input  cnn_buf_pkg::sel_t        read_state,
    input  cnn_buf_pkg::load_word_t  load_data,
    output cnn_buf_pkg::operand_t    operand,
    output logic                     load_done,
    output cnn_buf_pkg::mem_status_t mem_state
);

    logic bias_wr;
    logic bias_rd;
    logic bias_full;
    logic bias_empty;
    logic weight_wr;
    logic weight_rd;
    logic weight_full;
    logic weight_empty;
    logic layer_we;
    logic layer_re;
    logic store_clr;

    cnn_buf_pkg::layer_addr_t layer_wr_addr;
    cnn_buf_pkg::layer_addr_t layer_rd_addr;
    cnn_buf_pkg::sel_t        rd_issue;
    cnn_buf_pkg::bias_t       bias_dout;
    cnn_buf_pkg::weight_t     weight_dout;
    cnn_buf_pkg::layer_t      layer_dout;

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    mem_ctrl u_mem_ctrl (
        .clk           (clk),
        .rst           (rst),
        .ena           (ena),
        .clear         (clear),
        .load_state    (load_state),
        .read_state    (read_state),
        .bias_full     (bias_full),
        .bias_empty    (bias_empty),
        .weight_full   (weight_full),
        .weight_empty  (weight_empty),
        .bias_wr       (bias_wr),
        .bias_rd       (bias_rd),
        .weight_wr     (weight_wr),
        .weight_rd     (weight_rd),
        .layer_we      (layer_we),
        .layer_re      (layer_re),
        .store_clr     (store_clr),
        .layer_wr_addr (layer_wr_addr),
        .layer_rd_addr (layer_rd_addr),
        .rd_issue      (rd_issue),
        .load_done     (load_done),
        .mem_state     (mem_state)
    );

    //////////////////////////////////////////////////////////////////////
    // Stores
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .T     (cnn_buf_pkg::bias_t),
        .DEPTH (`CNN_FIFO_DEPTH)
    ) u_bias_fifo (
        .clk   (clk),
        .rst   (rst),
        .clr   (store_clr),
        .wr    (bias_wr),
        .rd    (bias_rd),
        .din   (load_data.bias),
        .dout  (bias_dout),
        .full  (bias_full),
        .empty (bias_empty)
    );

    sync_fifo #(
        .T     (cnn_buf_pkg::weight_t),
        .DEPTH (`CNN_FIFO_DEPTH)
    ) u_weight_fifo (
        .clk   (clk),
        .rst   (rst),
        .clr   (store_clr),
        .wr    (weight_wr),
        .rd    (weight_rd),
        .din   (load_data.weight),
        .dout  (weight_dout),
        .full  (weight_full),
        .empty (weight_empty)
    );

    layer_ram u_layer_ram (
        .clk     (clk),
        .we      (layer_we),
        .wr_addr (layer_wr_addr),
        .rd_addr (layer_rd_addr),
        .wr_data (load_data.layer),
        .re      (layer_re),
        .rd_data (layer_dout)
    );

    // Operand alignment
    operand_gather u_operand_gather (
        .clk         (clk),
        .rst         (rst),
        .rd_issue    (rd_issue),
        .bias_data   (bias_dout),
        .weight_data (weight_dout),
        .layer_data  (layer_dout),
        .operand     (operand)
    );

endmodule

//--- cnn_buf_chk.sv
`timescale 1ns/1ps

module cnn_buf_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  bias_wr,
    input logic                  bias_rd,
    input logic                  bias_full,
    input logic                  bias_empty,
    input logic                  weight_wr,
    input logic                  weight_rd,
    input logic                  weight_full,
    input logic                  weight_empty,
    input cnn_buf_pkg::sel_t     rd_issue,
    input cnn_buf_pkg::operand_t operand,
    input logic                  load_done
);

    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // FIFO access rules
    //////////////////////////////////////////////////////////////////////

    no_overrun: assert property (@(posedge clk) disable iff (rst)
        !(bias_wr && bias_full) && !(weight_wr && weight_full))
    else
    begin
        fail_count++;
        $error("FIFO written while full");
    end

    no_underrun: assert property (@(posedge clk) disable iff (rst)
        !(bias_rd && bias_empty) && !(weight_rd && weight_empty))
    else
    begin
        fail_count++;
        $error("FIFO read while empty");
    end

    // Valid bits trail the issued reads by two cycles
    valid_lag: assert property (@(posedge clk) disable iff (rst)
        operand.valid == $past(rd_issue, 2))
    else
    begin
        fail_count++;
        $error("operand valid does not match rd_issue two cycles earlier");
    end

    done_after_reset: assert property (@(posedge clk) $fell(rst) |-> !load_done)
    else
    begin
        fail_count++;
        $error("load_done set right after reset release");
    end

endmodule

bind cnn_buf_top cnn_buf_chk u_cnn_buf_chk (
    .clk          (clk),
    .rst          (rst),
    .bias_wr      (bias_wr),
    .bias_rd      (bias_rd),
    .bias_full    (bias_full),
    .bias_empty   (bias_empty),
    .weight_wr    (weight_wr),
    .weight_rd    (weight_rd),
    .weight_full  (weight_full),
    .weight_empty (weight_empty),
    .rd_issue     (rd_issue),
    .operand      (operand),
    .load_done    (load_done)
);

//--- tb_cnn_buf.sv
`timescale 1ns/1ps
`include "cnn_buf_params.svh"

module tb_cnn_buf;

    localparam int FIFO_DEPTH  = `CNN_FIFO_DEPTH;
    localparam int LAYER_DEPTH = `CNN_LAYER_DEPTH;

    logic                     clk;
    logic                     rst;
    logic                     ena;
    logic                     clear;
    cnn_buf_pkg::sel_t        load_state;
    cnn_buf_pkg::sel_t        read_state;
    cnn_buf_pkg::load_word_t  load_data;
    cnn_buf_pkg::operand_t    operand;
    logic                     load_done;
    cnn_buf_pkg::mem_status_t mem_state;

    // Reference model
    cnn_buf_pkg::bias_t       bias_q [$];
    cnn_buf_pkg::weight_t     weight_q [$];
    cnn_buf_pkg::layer_t      layer_mem [LAYER_DEPTH];
    int                       m_wr_ptr;
    int                       m_rd_ptr;
    cnn_buf_pkg::operand_t    pend_op;
    cnn_buf_pkg::operand_t    exp_op;
    logic                     exp_load_done;
    cnn_buf_pkg::mem_status_t exp_state;

    integer seed;
    int     checks;
    int     check_errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;

    cnn_buf_top UUT (
        .clk        (clk),
        .rst        (rst),
        .ena        (ena),
        .clear      (clear),
        .load_state (load_state),
        .read_state (read_state),
        .load_data  (load_data),
        .operand    (operand),
        .load_done  (load_done),
        .mem_state  (mem_state)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Random stimulus and checking helpers
    //////////////////////////////////////////////////////////////////////

    function automatic cnn_buf_pkg::sel_t rand_sel();
        logic [31:0] r;
        r = $random(seed);
        return r[2:0];
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic cnn_buf_pkg::load_word_t rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[39:0];
    endfunction

    task automatic expect_true(input logic ok, input string msg);
    begin
        checks++;
        assert (ok === 1'b1)
        else
        begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            check_errors++;
            test_errors++;
        end
    end
    endtask

    task automatic compare_outputs();
    begin
        expect_true(operand.valid === exp_op.valid,
            $sformatf("operand valid %b, expected %b", operand.valid, exp_op.valid));
        // Unread fields hold their last data
        expect_true(operand.bias === exp_op.bias,
            $sformatf("bias %h, expected %h", operand.bias, exp_op.bias));
        expect_true(operand.weight === exp_op.weight,
            $sformatf("weight %h, expected %h", operand.weight, exp_op.weight));
        expect_true(operand.layer === exp_op.layer,
            $sformatf("layer %h, expected %h", operand.layer, exp_op.layer));
        expect_true(load_done === exp_load_done,
            $sformatf("load_done %b, expected %b", load_done, exp_load_done));
        expect_true(mem_state === exp_state,
            $sformatf("mem_state %b, expected %b", mem_state, exp_state));
    end
    endtask

    // Drive, predict, clock and compare one cycle
    task automatic run_cycle(input logic en, input logic clr, input cnn_buf_pkg::sel_t ld,
                             input cnn_buf_pkg::sel_t rd, input cnn_buf_pkg::load_word_t data);
        logic                     acc;
        logic                     b_wr;
        logic                     b_rd;
        logic                     w_wr;
        logic                     w_rd;
        logic                     l_we;
        logic                     l_re;
        cnn_buf_pkg::operand_t    issued;
        cnn_buf_pkg::mem_status_t flags;
    begin
        ena        = en;
        clear      = clr;
        load_state = ld;
        read_state = rd;
        load_data  = data;
        acc  = en && !clr;
        b_wr = acc && ld.bias && (bias_q.size() < FIFO_DEPTH);
        w_wr = acc && ld.weight && (weight_q.size() < FIFO_DEPTH);
        b_rd = acc && rd.bias && (bias_q.size() > 0);
        w_rd = acc && rd.weight && (weight_q.size() > 0);
        l_we = acc && ld.layer;
        l_re = acc && rd.layer;
        issued = '0;
        issued.valid.bias   = b_rd;
        issued.valid.weight = w_rd;
        issued.valid.layer  = l_re;
        if (b_rd)
            issued.bias = bias_q[0];
        if (w_rd)
            issued.weight = weight_q[0];
        // Old word on a same-address collision
        if (l_re)
            issued.layer = layer_mem[m_rd_ptr];
        flags.bias_full    = (bias_q.size() == FIFO_DEPTH);
        flags.bias_empty   = (bias_q.size() == 0);
        flags.weight_full  = (weight_q.size() == FIFO_DEPTH);
        flags.weight_empty = (weight_q.size() == 0);
        @(posedge clk);
        #1;
        // Second stage of the read pipeline
        exp_op.valid = pend_op.valid;
        if (pend_op.valid.bias)
            exp_op.bias = pend_op.bias;
        if (pend_op.valid.weight)
            exp_op.weight = pend_op.weight;
        if (pend_op.valid.layer)
            exp_op.layer = pend_op.layer;
        pend_op = issued;
        if (en)
        begin
            exp_load_done = (ld == '0);
            exp_state     = flags;
        end
        if (en && clr)
        begin
            bias_q.delete();
            weight_q.delete();
            m_wr_ptr = 0;
            m_rd_ptr = 0;
        end
        else
        begin
            if (b_rd)
                void'(bias_q.pop_front());
            if (b_wr)
                bias_q.push_back(data.bias);
            if (w_rd)
                void'(weight_q.pop_front());
            if (w_wr)
                weight_q.push_back(data.weight);
            if (l_we)
            begin
                layer_mem[m_wr_ptr] = data.layer;
                m_wr_ptr = (m_wr_ptr + 1) % LAYER_DEPTH;
            end
            if (l_re)
                m_rd_ptr = (m_rd_ptr + 1) % LAYER_DEPTH;
        end
        compare_outputs();
        #1;
    end
    endtask

    // Repeats one access pattern until the status shows every flag in want
    task automatic wait_for_state(input cnn_buf_pkg::mem_status_t want,
                                  input cnn_buf_pkg::sel_t ld, input cnn_buf_pkg::sel_t rd,
                                  input int limit, input string what);
        int n;
    begin
        n = 0;
        while ((mem_state & want) !== want)
        begin
            if (n == limit)
            begin
                $display("Timeout: FIFOs never became %s within %0d cycles", what, limit);
                $display("RESULT: FAIL");
                $finish;
            end
            else
            begin
                run_cycle(1'b1, 1'b0, ld, rd, rand_word());
                n++;
            end
        end
    end
    endtask

    task automatic finish_test(input string name);
    begin
        tests_run++;
        if (test_errors == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d checks failed", name, test_errors);
        end
        test_errors = 0;
    end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        ena = 1'b0;
        clear = 1'b0;
        load_state = '0;
        read_state = '0;
        load_data = '0;
        seed = 80212;
        checks = 0;
        check_errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        m_wr_ptr = 0;
        m_rd_ptr = 0;
        pend_op = '0;
        exp_op = '0;
        exp_load_done = 1'b0;
        exp_state = 4'b0101;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        compare_outputs();
        expect_true(operand.valid === 3'b000, "operand valid set after reset");
        finish_test("reset values");

        // Random load and read vectors with layer reads held off
        repeat (200) run_cycle(1'b1, 1'b0, rand_sel(), rand_sel() & 3'b110, rand_word());
        wait_for_state(4'b0101, 3'b000, 3'b110, 40, "empty");
        repeat (3) run_cycle(1'b1, 1'b0, 3'b000, 3'b110, rand_word());
        finish_test("fifo order");

        wait_for_state(4'b1010, 3'b110, 3'b000, 20, "full");
        repeat (4) run_cycle(1'b1, 1'b0, 3'b110, 3'b000, rand_word());
        wait_for_state(4'b0101, 3'b000, 3'b110, 20, "empty");
        repeat (2) run_cycle(1'b1, 1'b0, 3'b000, 3'b000, rand_word());
        finish_test("full blocking");

        // Fill every address and then overlap writes and reads with wrap
        run_cycle(1'b1, 1'b1, 3'b000, 3'b000, rand_word());
        repeat (LAYER_DEPTH) run_cycle(1'b1, 1'b0, 3'b001, 3'b000, rand_word());
        repeat (24) run_cycle(1'b1, 1'b0, 3'b001, 3'b001, rand_word());
        repeat (LAYER_DEPTH) run_cycle(1'b1, 1'b0, 3'b000, 3'b001, rand_word());
        repeat (2) run_cycle(1'b1, 1'b0, 3'b000, 3'b000, rand_word());
        finish_test("layer ram");

        repeat (5) run_cycle(1'b1, 1'b0, 3'b111, 3'b000, rand_word());
        run_cycle(1'b0, 1'b1, 3'b000, 3'b000, rand_word());
        run_cycle(1'b1, 1'b1, 3'b000, 3'b000, rand_word());
        repeat (2) run_cycle(1'b1, 1'b0, 3'b000, 3'b111, rand_word());
        repeat (20)
            run_cycle(1'b1, 1'b0, rand_bit() ? rand_sel() : 3'b000, 3'b000, rand_word());
        repeat (2) run_cycle(1'b1, 1'b0, 3'b000, 3'b000, rand_word());
        finish_test("clear and done");

        // Reads in flight still land while ena is low
        repeat (4) run_cycle(1'b1, 1'b0, 3'b110, 3'b000, rand_word());
        run_cycle(1'b1, 1'b0, 3'b000, 3'b111, rand_word());
        repeat (20) run_cycle(1'b0, rand_bit(), rand_sel(), rand_sel(), rand_word());
        wait_for_state(4'b0101, 3'b000, 3'b110, 20, "empty");
        repeat (2) run_cycle(1'b1, 1'b0, 3'b000, 3'b000, rand_word());
        finish_test("ena low");

        $display("Tests %0d, failed %0d, checks %0d, check failures %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, check_errors, UUT.u_cnn_buf_chk.fail_count);
        if (check_errors == 0 && UUT.u_cnn_buf_chk.fail_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
cnn_buf_pkg.sv
mem_ctrl.sv
sync_fifo.sv
layer_ram.sv
operand_gather.sv
cnn_buf_top.sv
cnn_buf_chk.sv
tb_cnn_buf.sv

//--- Bender.yml
package:
  name: cnn_buf

export_include_dirs:
  - .

sources:
  - cnn_buf_pkg.sv
  - mem_ctrl.sv
  - sync_fifo.sv
  - layer_ram.sv
  - operand_gather.sv
  - cnn_buf_top.sv
  - target: simulation
    files:
      - cnn_buf_chk.sv
      - tb_cnn_buf.sv
